// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_vic_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/reg_write_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_write_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                    clk_vga,
   input  wire logic                    pwr_up_reset_n,
   input  wire logic                    i_push,
   input  wire vic_bus_pkg::reg_write_t i_push_data,
   input  wire logic                    i_pop,
   output vic_bus_pkg::reg_write_t      o_pop_data,
   output logic                         o_full,
   output logic                         o_empty
);

   import vic_bus_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // Storage, payload only
   reg_write_t       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;

   // Status from occupancy
   assign o_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign o_empty = (count == '0);

   // Head entry shown directly
   assign o_pop_data = mem[rd_ptr];

   always_ff @(posedge clk_vga) begin
      if (i_push) begin
         mem[wr_ptr] <= i_push_data;
      end
   end

   // Pointers wrap naturally for a power-of-two depth
   always_ff @(posedge clk_vga) begin
      if (!pwr_up_reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keep the count
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk_vga) disable iff (!pwr_up_reset_n)
      o_full |-> !i_push);
   a_no_underflow: assert property (@(posedge clk_vga) disable iff (!pwr_up_reset_n)
      o_empty |-> !i_pop);

endmodule

`default_nettype wire

// ==== hdl/vic_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_axil_slave (
   input  wire logic                  clk_vga,
   input  wire logic                  pwr_up_reset_n,
   input  wire vic_bus_pkg::axil_aw_t i_aw,
   input  wire vic_bus_pkg::axil_w_t  i_w,
   input  wire logic                  i_bready,
   input  wire vic_bus_pkg::axil_ar_t i_ar,
   input  wire logic                  i_rready,
   input  wire logic                  i_q_full,
   input  wire logic                  i_q_empty,
   input  wire logic [7:0]            i_rd_data,
   output logic                       o_awready,
   output logic                       o_wready,
   output vic_bus_pkg::axil_b_t       o_b,
   output logic                       o_arready,
   output vic_bus_pkg::axil_r_t       o_r,
   output logic                       o_push,
   output vic_bus_pkg::reg_write_t    o_push_data,
   output logic [3:0]                 o_rd_index
);

   import vic_bus_pkg::*;

   logic wr_accept;
   logic rd_accept;
   logic wr_in_window;
   logic rd_in_window;

   // Window decode on the upper twelve address bits
   assign wr_in_window = (i_aw.addr[15:4] == VIC_BASE_HI);
   assign rd_in_window = (i_ar.addr[15:4] == VIC_BASE_HI);

   // ==========================================================
   // Write channel
   // ==========================================================

   // AW and W taken together
   // Stall while a response waits or the queue is full
   assign o_awready = i_aw.valid && i_w.valid && !o_b.valid && !i_q_full;
   assign o_wready  = o_awready;
   assign wr_accept = o_awready;

   // Only in-window writes with the lane enabled reach the queue
   assign o_push      = wr_accept && wr_in_window && i_w.strb;
   assign o_push_data = '{index: i_aw.addr[3:0], data: i_w.data};

   always_ff @(posedge clk_vga) begin
      if (!pwr_up_reset_n) begin
         o_b <= '0;
      end else if (wr_accept) begin
         o_b.valid <= 1'b1;
         o_b.resp  <= wr_in_window ? RESP_OKAY : RESP_SLVERR;
      end else if (i_bready) begin
         o_b.valid <= 1'b0;
      end
   end

   // ==========================================================
   // Read channel
   // ==========================================================

   // Reads wait for the queue to drain
   assign o_arready  = i_ar.valid && i_q_empty && !o_r.valid;
   assign rd_accept  = o_arready;
   assign o_rd_index = i_ar.addr[3:0];

   always_ff @(posedge clk_vga) begin
      if (!pwr_up_reset_n) begin
         o_r <= '0;
      end else if (rd_accept) begin
         o_r.valid <= 1'b1;
         o_r.data  <= rd_in_window ? i_rd_data : 8'h00;
         o_r.resp  <= rd_in_window ? RESP_OKAY : RESP_SLVERR;
      end else if (i_rready) begin
         o_r.valid <= 1'b0;
      end
   end

   // Master keeps each request and its payload until the handshake
   a_aw_hold: assert property (@(posedge clk_vga) disable iff (!pwr_up_reset_n)
      i_aw.valid && !o_awready |=> i_aw.valid && $stable(i_aw));
   a_w_hold: assert property (@(posedge clk_vga) disable iff (!pwr_up_reset_n)
      i_w.valid && !o_wready |=> i_w.valid && $stable(i_w));
   a_ar_hold: assert property (@(posedge clk_vga) disable iff (!pwr_up_reset_n)
      i_ar.valid && !o_arready |=> i_ar.valid && $stable(i_ar));

endmodule

`default_nettype wire

// ==== hdl/vic_bus_pkg.sv ====
`default_nettype none

package vic_bus_pkg;

   // ==========================================================
   // AXI4-Lite channel payloads
   // ==========================================================

   // Write address
   typedef struct packed {
      logic [15:0] addr;
      logic        valid;
   } axil_aw_t;

   // Write data with a single byte lane
   typedef struct packed {
      logic [7:0] data;
      logic       strb;
      logic       valid;
   } axil_w_t;

   // Write response
   typedef struct packed {
      logic [1:0] resp;
      logic       valid;
   } axil_b_t;

   // Read address
   typedef struct packed {
      logic [15:0] addr;
      logic        valid;
   } axil_ar_t;

   // Read data and response
   typedef struct packed {
      logic [7:0] data;
      logic [1:0] resp;
      logic       valid;
   } axil_r_t;

   // ==========================================================
   // Write queue record and bus constants
   // ==========================================================

   // One pending register write
   typedef struct packed {
      logic [3:0] index;
      logic [7:0] data;
   } reg_write_t;

   // Register window 0x9000 to 0x900F
   localparam logic [11:0] VIC_BASE_HI = 12'h900;

   // Response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== hdl/vic_register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_register_bank (
   input  wire logic                    clk_vga,
   input  wire logic                    pwr_up_reset_n,
   input  wire logic                    i_empty,
   input  wire vic_bus_pkg::reg_write_t i_pop_data,
   input  wire logic [3:0]              i_rd_index,
   output logic                         o_pop,
   output logic [7:0]                   o_rd_data,
   output vic_regs_pkg::video_cfg_t     o_video_cfg,
   output vic_regs_pkg::sound_cfg_t     o_sound_cfg
);

   import vic_regs_pkg::*;

   logic [3:0] wr_index;
   logic [7:0] wr_data;

   // Drain one write per cycle
   assign o_pop    = !i_empty;
   assign wr_index = i_pop_data.index;
   assign wr_data  = i_pop_data.data;

   // ==========================================================
   // Register update
   // ==========================================================

   always_ff @(posedge clk_vga) begin
      if (!pwr_up_reset_n) begin
         o_video_cfg <= VIDEO_CFG_RESET;
         o_sound_cfg <= '0;
      end else if (o_pop) begin
         case (wr_index)
            REG_XORIGIN: o_video_cfg.xorigin <= wr_data[6:0];
            REG_YORIGIN: o_video_cfg.yorigin <= wr_data;
            // Bit 7 extends screen and colour RAM addresses
            REG_COLS: begin
               o_video_cfg.screen_addr[9]    <= wr_data[7];
               o_video_cfg.color_ram_addr[9] <= wr_data[7];
               o_video_cfg.cols              <= wr_data[6:0];
            end
            // Rows above the tall-character flag
            REG_ROWS: begin
               o_video_cfg.rows      <= wr_data[6:1];
               o_video_cfg.chars8x16 <= wr_data[0];
            end
            // Upper nibble screen base, lower nibble character base
            // Top address bit stored inverted
            REG_BASE: begin
               o_video_cfg.screen_addr[15]      <= ~wr_data[7];
               o_video_cfg.screen_addr[12:10]   <= wr_data[6:4];
               o_video_cfg.char_rom_addr[15]    <= ~wr_data[3];
               o_video_cfg.char_rom_addr[12:10] <= wr_data[2:0];
            end
            REG_VOICE_BASS:    o_sound_cfg.bass    <= wr_data;
            REG_VOICE_ALTO:    o_sound_cfg.alto    <= wr_data;
            REG_VOICE_SOPRANO: o_sound_cfg.soprano <= wr_data;
            REG_VOICE_NOISE:   o_sound_cfg.noise   <= wr_data;
            // Aux colour shares the volume register
            REG_VOLUME: begin
               o_video_cfg.aux_color <= wr_data[7:4];
               o_sound_cfg.amplitude <= wr_data[3:0];
            end
            REG_COLOR: begin
               o_video_cfg.back_color   <= wr_data[7:4];
               o_video_cfg.inverted     <= wr_data[3];
               o_video_cfg.border_color <= wr_data[2:0];
            end
            // Raster and unused indices ignore writes
            default: begin
            end
         endcase
      end
   end

   // ==========================================================
   // Readback
   // ==========================================================

   always_comb begin
      case (i_rd_index)
         REG_XORIGIN:       o_rd_data = {1'b0, o_video_cfg.xorigin};
         REG_YORIGIN:       o_rd_data = o_video_cfg.yorigin;
         // Colour RAM copy of bit 9, equal to the screen copy after any write
         REG_COLS:          o_rd_data = {o_video_cfg.color_ram_addr[9], o_video_cfg.cols};
         REG_ROWS:          o_rd_data = {1'b0, o_video_cfg.rows, o_video_cfg.chars8x16};
         REG_BASE: begin
            o_rd_data = {~o_video_cfg.screen_addr[15], o_video_cfg.screen_addr[12:10],
                         ~o_video_cfg.char_rom_addr[15], o_video_cfg.char_rom_addr[12:10]};
         end
         REG_VOICE_BASS:    o_rd_data = o_sound_cfg.bass;
         REG_VOICE_ALTO:    o_rd_data = o_sound_cfg.alto;
         REG_VOICE_SOPRANO: o_rd_data = o_sound_cfg.soprano;
         REG_VOICE_NOISE:   o_rd_data = o_sound_cfg.noise;
         REG_VOLUME:        o_rd_data = {o_video_cfg.aux_color, o_sound_cfg.amplitude};
         REG_COLOR: begin
            o_rd_data = {o_video_cfg.back_color, o_video_cfg.inverted,
                         o_video_cfg.border_color};
         end
         // Raster line and 6 to 9
         default:           o_rd_data = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/vic_regs_pkg.sv ====
`default_nettype none

package vic_regs_pkg;

   // ==========================================================
   // Register indices inside the window
   // ==========================================================

   localparam logic [3:0] REG_XORIGIN       = 4'h0;
   localparam logic [3:0] REG_YORIGIN       = 4'h1;
   localparam logic [3:0] REG_COLS          = 4'h2;
   localparam logic [3:0] REG_ROWS          = 4'h3;
   // Raster line, reads zero without video timing
   localparam logic [3:0] REG_RASTER        = 4'h4;
   localparam logic [3:0] REG_BASE          = 4'h5;
   localparam logic [3:0] REG_VOICE_BASS    = 4'hA;
   localparam logic [3:0] REG_VOICE_ALTO    = 4'hB;
   localparam logic [3:0] REG_VOICE_SOPRANO = 4'hC;
   localparam logic [3:0] REG_VOICE_NOISE   = 4'hD;
   localparam logic [3:0] REG_VOLUME        = 4'hE;
   localparam logic [3:0] REG_COLOR         = 4'hF;

   // ==========================================================
   // Video and sound configuration
   // ==========================================================

   // Screen geometry, base addresses and colours
   typedef struct packed {
      logic [6:0]  xorigin;
      logic [7:0]  yorigin;
      logic [6:0]  cols;
      logic [5:0]  rows;
      logic        chars8x16;
      logic [15:0] screen_addr;
      logic [15:0] char_rom_addr;
      logic [15:0] color_ram_addr;
      logic [3:0]  aux_color;
      logic [2:0]  border_color;
      logic        inverted;
      logic [3:0]  back_color;
   } video_cfg_t;

   // One voice register
   typedef struct packed {
      logic       enable;
      logic [6:0] rate;
   } voice_t;

   // Four voices plus master volume
   typedef struct packed {
      voice_t     bass;
      voice_t     alto;
      voice_t     soprano;
      voice_t     noise;
      logic [3:0] amplitude;
   } sound_cfg_t;

   // Power-up screen layout
   localparam video_cfg_t VIDEO_CFG_RESET = '{
      xorigin:        7'd12,
      yorigin:        8'd38,
      cols:           7'd22,
      rows:           6'd23,
      chars8x16:      1'b0,
      screen_addr:    16'h1E00,
      char_rom_addr:  16'h8000,
      color_ram_addr: 16'h9400,
      aux_color:      4'h0,
      border_color:   3'h0,
      inverted:       1'b0,
      back_color:     4'h0
   };

   // Mixer output width
   localparam int AUDIO_W = 6;
   // Audio clock-enable divider length
   localparam int CLK_DIV = 24;

endpackage

`default_nettype wire

// ==== hdl/vic_sound.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_sound (
   input  wire logic                       clk_vga,
   input  wire logic                       pwr_up_reset_n,
   input  wire vic_regs_pkg::sound_cfg_t   i_sound_cfg,
   output logic [vic_regs_pkg::AUDIO_W-1:0] o_audio
);

   import vic_regs_pkg::*;

   localparam int          DIV_W     = $clog2(CLK_DIV);
   localparam logic [15:0] LFSR_SEED = 16'hACE1;

   logic [DIV_W-1:0] div_cnt;
   logic             tick;
   logic [1:0]       tick_cnt;
   logic [3:0]       step;
   logic [3:0]       wrap;
   voice_t           voices [4];
   logic [6:0]       voice_cnt [4];
   logic [2:0]       square;
   logic [15:0]      lfsr;
   logic [3:0]       voice_out;
   logic [2:0]       active;

   // ==========================================================
   // Clock enable
   // ==========================================================

   // Counts 0 to 23, tick on 0, 4, 8 and 12
   assign tick = (div_cnt[1:0] == 2'b00) && !div_cnt[DIV_W-1];

   always_ff @(posedge clk_vga) begin
      if (!pwr_up_reset_n) begin
         div_cnt  <= '0;
         tick_cnt <= '0;
      end else begin
         div_cnt <= (div_cnt == DIV_W'(CLK_DIV - 1)) ? '0 : div_cnt + 1'b1;
         if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   // ==========================================================
   // Voices
   // ==========================================================

   // Index 0 bass up to 3 noise
   assign voices[0] = i_sound_cfg.bass;
   assign voices[1] = i_sound_cfg.alto;
   assign voices[2] = i_sound_cfg.soprano;
   assign voices[3] = i_sound_cfg.noise;

   // Bass every 4th tick, alto every 2nd, soprano and noise every tick
   assign step[0] = tick && (tick_cnt == 2'b11);
   assign step[1] = tick && tick_cnt[0];
   assign step[2] = tick;
   assign step[3] = tick;

   always_comb begin
      for (int v = 0; v < 4; v++) begin
         wrap[v] = step[v] && (voice_cnt[v] == 7'h7F);
      end
   end

   // Counter reloads with the rate at its top
   always_ff @(posedge clk_vga) begin
      if (!pwr_up_reset_n) begin
         for (int v = 0; v < 4; v++) begin
            voice_cnt[v] <= '0;
         end
         square <= '0;
         lfsr   <= LFSR_SEED;
      end else begin
         for (int v = 0; v < 4; v++) begin
            if (wrap[v]) begin
               voice_cnt[v] <= voices[v].rate;
            end else if (step[v]) begin
               voice_cnt[v] <= voice_cnt[v] + 1'b1;
            end
         end
         for (int v = 0; v < 3; v++) begin
            if (wrap[v]) begin
               square[v] <= ~square[v];
            end
         end
         // Galois shift on each noise wrap
         if (wrap[3]) begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
         end
      end
   end

   assign voice_out = {lfsr[0], square};

   // ==========================================================
   // Mixer
   // ==========================================================

   always_comb begin
      active = '0;
      for (int v = 0; v < 4; v++) begin
         if (voices[v].enable && voice_out[v]) begin
            active = active + 3'd1;
         end
      end
   end

   // Volume times high voices, at most 15 x 4
   assign o_audio = AUDIO_W'(i_sound_cfg.amplitude) * AUDIO_W'(active);

endmodule

`default_nettype wire

// ==== hdl/vic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_top #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                        clk_vga,
   input  wire logic                        pwr_up_reset_n,
   input  wire vic_bus_pkg::axil_aw_t       i_aw,
   input  wire vic_bus_pkg::axil_w_t        i_w,
   input  wire logic                        i_bready,
   input  wire vic_bus_pkg::axil_ar_t       i_ar,
   input  wire logic                        i_rready,
   output logic                             o_awready,
   output logic                             o_wready,
   output vic_bus_pkg::axil_b_t             o_b,
   output logic                             o_arready,
   output vic_bus_pkg::axil_r_t             o_r,
   output vic_regs_pkg::video_cfg_t         o_video_cfg,
   output logic [vic_regs_pkg::AUDIO_W-1:0] o_audio
);

   import vic_bus_pkg::*;
   import vic_regs_pkg::*;

   // Slave to queue
   logic       q_push;
   reg_write_t q_push_data;
   logic       q_full;
   logic       q_empty;
   // Queue to register bank
   logic       q_pop;
   reg_write_t q_pop_data;
   // Readback
   logic [3:0] rd_index;
   logic [7:0] rd_data;
   sound_cfg_t sound_cfg;

   // ==========================================================
   // Host side
   // ==========================================================

   vic_axil_slave slave_i (
      .clk_vga        (clk_vga),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_aw           (i_aw),
      .i_w            (i_w),
      .i_bready       (i_bready),
      .i_ar           (i_ar),
      .i_rready       (i_rready),
      .i_q_full       (q_full),
      .i_q_empty      (q_empty),
      .i_rd_data      (rd_data),
      .o_awready      (o_awready),
      .o_wready       (o_wready),
      .o_b            (o_b),
      .o_arready      (o_arready),
      .o_r            (o_r),
      .o_push         (q_push),
      .o_push_data    (q_push_data),
      .o_rd_index     (rd_index)
   );

   reg_write_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_i (
      .clk_vga        (clk_vga),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_push         (q_push),
      .i_push_data    (q_push_data),
      .i_pop          (q_pop),
      .o_pop_data     (q_pop_data),
      .o_full         (q_full),
      .o_empty        (q_empty)
   );

   // ==========================================================
   // Registers and sound
   // ==========================================================

   vic_register_bank bank_i (
      .clk_vga        (clk_vga),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_empty        (q_empty),
      .i_pop_data     (q_pop_data),
      .i_rd_index     (rd_index),
      .o_pop          (q_pop),
      .o_rd_data      (rd_data),
      .o_video_cfg    (o_video_cfg),
      .o_sound_cfg    (sound_cfg)
   );

   vic_sound sound_i (
      .clk_vga        (clk_vga),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_sound_cfg    (sound_cfg),
      .o_audio        (o_audio)
   );

endmodule

`default_nettype wire

// ==== verification/tb_vic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vic_top;

   import vic_bus_pkg::*;
   import vic_regs_pkg::*;

   // Bus tests take a few hundred cycles
   // Soprano may need 128 ticks of 6 cycles before its first reload
   localparam int          RESET_CYCLES    = 8;
   localparam int          BUS_TEST_CYCLES = 400;
   localparam int          SOUND_SETTLE    = 800;
   localparam int          SOUND_WINDOW    = 200;
   localparam int          TIMEOUT_CYCLES  =
      2 * (RESET_CYCLES + BUS_TEST_CYCLES + SOUND_SETTLE + 2 * SOUND_WINDOW);
   localparam logic [15:0] LFSR_TAPS       = 16'hD008;

   logic               clk_vga;
   logic               pwr_up_reset_n;
   axil_aw_t           i_aw;
   axil_w_t            i_w;
   logic               i_bready;
   axil_ar_t           i_ar;
   logic               i_rready;
   logic               o_awready;
   logic               o_wready;
   axil_b_t            o_b;
   logic               o_arready;
   axil_r_t            o_r;
   video_cfg_t         o_video_cfg;
   logic [AUDIO_W-1:0] o_audio;

   // Expected state
   video_cfg_t  exp_cfg;
   logic [7:0]  exp_reg [16];
   logic [15:0] lfsr_state  = 16'd30486;
   int          checks      = 0;
   int          errors      = 0;
   int          cycle_count = 0;

   vic_top #(
      .FIFO_DEPTH (4)
   ) dut_i (
      .clk_vga        (clk_vga),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_aw           (i_aw),
      .i_w            (i_w),
      .i_bready       (i_bready),
      .i_ar           (i_ar),
      .i_rready       (i_rready),
      .o_awready      (o_awready),
      .o_wready       (o_wready),
      .o_b            (o_b),
      .o_arready      (o_arready),
      .o_r            (o_r),
      .o_video_cfg    (o_video_cfg),
      .o_audio        (o_audio)
   );

   initial begin
      clk_vga = 1'b0;
      forever #2 clk_vga = ~clk_vga;
   end

   // Watchdog
   always @(posedge clk_vga) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
         $display("Finished with errors");
         $finish;
      end
   end

   // ==========================================================
   // Checks, stimulus source and reference model
   // ==========================================================

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1) else begin
         errors++;
         $display("Error: %s", what);
      end
   endtask

   // One LFSR step per bit taken
   function automatic logic [7:0] random_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[6:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 16'h0000);
      end
      return v;
   endfunction

   function automatic logic [7:0] random_byte();
      return random_bits(8);
   endfunction

   function automatic logic [15:0] reg_addr(input logic [3:0] idx);
      return {12'h900, idx};
   endfunction

   // Power-up layout and readback
   task automatic reset_model();
      exp_cfg                = '0;
      exp_cfg.xorigin        = 7'd12;
      exp_cfg.yorigin        = 8'd38;
      exp_cfg.cols           = 7'd22;
      exp_cfg.rows           = 6'd23;
      exp_cfg.screen_addr    = 16'h1E00;
      exp_cfg.char_rom_addr  = 16'h8000;
      exp_cfg.color_ram_addr = 16'h9400;
      for (int i = 0; i < 16; i++) begin
         exp_reg[i] = 8'h00;
      end
      exp_reg[0] = 8'd12;
      exp_reg[1] = 8'd38;
      exp_reg[2] = 8'd22;
      exp_reg[3] = 8'd46;
      // Screen base bit 15 reads back inverted
      exp_reg[5] = 8'hF0;
   endtask

   // Reference field mapping per register
   task automatic model_write(input logic [3:0] idx, input logic [7:0] d);
      case (idx)
         4'h0: exp_cfg.xorigin = d[6:0];
         4'h1: exp_cfg.yorigin = d;
         4'h2: begin
            exp_cfg.cols              = d[6:0];
            exp_cfg.screen_addr[9]    = d[7];
            exp_cfg.color_ram_addr[9] = d[7];
         end
         4'h3: begin
            exp_cfg.rows      = d[6:1];
            exp_cfg.chars8x16 = d[0];
         end
         4'h5: begin
            exp_cfg.screen_addr[15]      = ~d[7];
            exp_cfg.screen_addr[12:10]   = d[6:4];
            exp_cfg.char_rom_addr[15]    = ~d[3];
            exp_cfg.char_rom_addr[12:10] = d[2:0];
         end
         4'hE: exp_cfg.aux_color = d[7:4];
         4'hF: begin
            exp_cfg.back_color   = d[7:4];
            exp_cfg.inverted     = d[3];
            exp_cfg.border_color = d[2:0];
         end
         default: begin
         end
      endcase
      // Bit 7 has no storage in registers 0 and 3
      if (idx == 4'h0 || idx == 4'h3) begin
         exp_reg[idx] = {1'b0, d[6:0]};
      end else if (idx != 4'h4 && (idx < 4'h6 || idx > 4'h9)) begin
         exp_reg[idx] = d;
      end
   endtask

   // ==========================================================
   // AXI4-Lite master
   // ==========================================================

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_vga);
   endtask

   task automatic drive_write(input logic [15:0] addr, input logic [7:0] d, input logic strb);
      i_aw <= '{addr: addr, valid: 1'b1};
      i_w  <= '{data: d, strb: strb, valid: 1'b1};
   endtask

   task automatic wait_accept();
      @(posedge clk_vga);
      while (!(o_awready && o_wready)) @(posedge clk_vga);
      i_aw <= '0;
      i_w  <= '0;
   endtask

   task automatic write_response(output logic [1:0] resp);
      @(posedge clk_vga);
      while (!(o_b.valid && i_bready)) @(posedge clk_vga);
      resp = o_b.resp;
   endtask

   task automatic axil_write(input logic [15:0] addr, input logic [7:0] d,
                             output logic [1:0] resp);
      drive_write(addr, d, 1'b1);
      wait_accept();
      write_response(resp);
   endtask

   task automatic axil_read(input logic [15:0] addr, output logic [7:0] d,
                            output logic [1:0] resp);
      i_ar <= '{addr: addr, valid: 1'b1};
      @(posedge clk_vga);
      while (!o_arready) @(posedge clk_vga);
      i_ar <= '0;
      @(posedge clk_vga);
      while (!(o_r.valid && i_rready)) @(posedge clk_vga);
      d    = o_r.data;
      resp = o_r.resp;
   endtask

   // Reads drain the queue first, so o_video_cfg is final afterwards
   task automatic check_registers();
      logic [3:0] idx_list [7];
      logic [7:0] d;
      logic [1:0] resp;
      idx_list = '{REG_XORIGIN, REG_YORIGIN, REG_COLS, REG_ROWS, REG_BASE,
                   REG_VOLUME, REG_COLOR};
      foreach (idx_list[i]) begin
         axil_read(reg_addr(idx_list[i]), d, resp);
         check_value($sformatf("o_r.resp reg %0h", idx_list[i]), resp, RESP_OKAY);
         check_value($sformatf("o_r.data reg %0h", idx_list[i]), d, exp_reg[idx_list[i]]);
      end
      check_value("o_video_cfg", o_video_cfg, exp_cfg);
   endtask

   // ==========================================================
   // Directed tests
   // ==========================================================

   task automatic test_reset_values();
      logic [7:0] d;
      logic [1:0] resp;
      check_value("o_video_cfg", o_video_cfg, exp_cfg);
      check_value("o_audio", o_audio, 0);
      for (int i = 0; i < 4; i++) begin
         axil_read(reg_addr(4'(i)), d, resp);
         check_value($sformatf("o_r.resp reg %0d", i), resp, RESP_OKAY);
         check_value($sformatf("o_r.data reg %0d", i), d, exp_reg[i]);
      end
   endtask

   task automatic test_write_read();
      logic [3:0] idx_list [7];
      logic [7:0] d;
      logic [1:0] resp;
      idx_list = '{REG_XORIGIN, REG_YORIGIN, REG_COLS, REG_ROWS, REG_BASE,
                   REG_VOLUME, REG_COLOR};
      foreach (idx_list[i]) begin
         d = random_byte();
         axil_write(reg_addr(idx_list[i]), d, resp);
         model_write(idx_list[i], d);
         check_value("o_b.resp", resp, RESP_OKAY);
      end
      check_registers();
   endtask

   task automatic test_out_of_window();
      logic [7:0] d;
      logic [1:0] resp;
      axil_write(16'h9100, random_byte(), resp);
      check_value("o_b.resp", resp, RESP_SLVERR);
      axil_read(16'h9100, d, resp);
      check_value("o_r.resp", resp, RESP_SLVERR);
      check_value("o_r.data", d, 8'h00);
      check_registers();
   endtask

   task automatic test_backpressure();
      logic [7:0] d0;
      logic [7:0] d1;
      logic [7:0] d;
      logic [1:0] resp;
      d0 = random_byte();
      d1 = random_byte();
      // First response held back
      i_bready <= 1'b0;
      drive_write(reg_addr(REG_YORIGIN), d0, 1'b1);
      wait_accept();
      model_write(REG_YORIGIN, d0);
      drive_write(reg_addr(REG_XORIGIN), d1, 1'b1);
      repeat (10) begin
         @(posedge clk_vga);
         check_true(!o_awready && !o_wready,
                    "slave accepted a write while its response was held");
         check_true(o_b.valid, "write response dropped before the master took it");
      end
      i_bready <= 1'b1;
      write_response(resp);
      check_value("o_b.resp", resp, RESP_OKAY);
      // Stalled write goes through now
      wait_accept();
      model_write(REG_XORIGIN, d1);
      write_response(resp);
      check_value("o_b.resp", resp, RESP_OKAY);
      foreach (exp_reg[i]) begin
         if (i == 2 || i == 5 || i == 15) begin
            d = random_byte();
            axil_write(reg_addr(4'(i)), d, resp);
            model_write(4'(i), d);
            check_value("o_b.resp", resp, RESP_OKAY);
         end
      end
      check_registers();
   endtask

   // Checks every cycle that o_audio is 0 or amp
   task automatic watch_audio(input int n, input logic [3:0] amp,
                              output int zeros, output int highs);
      zeros = 0;
      highs = 0;
      repeat (n) begin
         @(posedge clk_vga);
         if (o_audio == 0) begin
            zeros++;
         end else if (o_audio == AUDIO_W'(amp)) begin
            highs++;
         end else begin
            check_value("o_audio", o_audio, amp);
         end
      end
   endtask

   task automatic test_sound();
      logic [3:0] amp;
      logic [3:0] aux;
      logic [1:0] resp;
      int         zeros;
      int         highs;
      amp = 4'(random_bits(4));
      aux = 4'(random_bits(4));
      if (amp == 4'h0) begin
         amp = 4'h9;
      end
      // Soprano at rate 0x7F but disabled
      axil_write(reg_addr(REG_VOICE_SOPRANO), 8'h7F, resp);
      axil_write(reg_addr(REG_VOLUME), {aux, amp}, resp);
      model_write(REG_VOLUME, {aux, amp});
      wait_cycles(2);
      watch_audio(SOUND_SETTLE, 4'h0, zeros, highs);
      check_true(zeros == SOUND_SETTLE, "o_audio was not zero with all voices disabled");
      // Soprano alone toggles once per tick
      axil_write(reg_addr(REG_VOICE_SOPRANO), 8'hFF, resp);
      wait_cycles(2);
      watch_audio(SOUND_WINDOW, amp, zeros, highs);
      check_true(zeros > 0, "o_audio never returned to zero with soprano enabled");
      check_true(highs > 0, "o_audio never reached the amplitude with soprano enabled");
      axil_write(reg_addr(REG_VOLUME), {aux, 4'h0}, resp);
      model_write(REG_VOLUME, {aux, 4'h0});
      wait_cycles(2);
      watch_audio(SOUND_WINDOW, 4'h0, zeros, highs);
      check_true(zeros == SOUND_WINDOW, "o_audio was not zero with amplitude zero");
      check_value("o_video_cfg", o_video_cfg, exp_cfg);
   endtask

   // ==========================================================
   // Main sequence
   // ==========================================================

   initial begin
      pwr_up_reset_n = 1'b0;
      i_aw           = '0;
      i_w            = '0;
      i_bready       = 1'b1;
      i_ar           = '0;
      i_rready       = 1'b1;
      reset_model();
      repeat (RESET_CYCLES) @(posedge clk_vga);
      pwr_up_reset_n <= 1'b1;
      @(posedge clk_vga);
      test_reset_values();
      test_write_read();
      test_out_of_window();
      test_backpressure();
      test_sound();
      $display("Checks run: %0d, errors counted: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/vic_bus_pkg.sv
hdl/vic_regs_pkg.sv
hdl/vic_axil_slave.sv
hdl/reg_write_fifo.sv
hdl/vic_register_bank.sv
hdl/vic_sound.sv
hdl/vic_top.sv
verification/tb_vic_top.sv
